// File: ecc.f
+incdir+.
ecc_pkg.sv
hamming_enc.sv
hamming_dec.sv
ecc_apb_regs.sv
ecc_top.sv
tb_ecc.sv

// File: ecc_apb_regs.sv
// APB3 register block for the SEC-DED datapath
// Decodes writes into commands and multiplexes status back onto prdata
`timescale 1ns/1ps

module ecc_apb_regs (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  ecc_pkg::apb_addr_t                paddr,
    input  logic [ecc_pkg::APB_DATA_W-1:0]    pwdata,
    output logic [ecc_pkg::APB_DATA_W-1:0]    prdata,
    output logic                              pready,
    output logic                              pslverr,
    output ecc_pkg::ecc_cmd_t                 cmd,
    input  ecc_pkg::code_word_t               code,
    input  ecc_pkg::ecc_result_t              result
);
    import ecc_pkg::*;

    logic       access;
    logic       wr_en;
    logic       rd_en;
    logic       wr_data;
    logic       wr_inject;
    logic       wr_ctrl;

    data_word_t data_q;
    code_word_t mask_q;
    logic [APB_DATA_W-1:0] rd_mux;

    // No wait states and no error responses
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign rd_en  = access && !pwrite;

    assign wr_data   = wr_en && (paddr == REG_DATA);
    assign wr_inject = wr_en && (paddr == REG_INJECT);
    assign wr_ctrl   = wr_en && (paddr == REG_CTRL);

    always_ff @(posedge clock) begin
        if (reset) begin
            data_q <= '0;
        end else if (wr_data) begin
            data_q <= pwdata[DATA_W-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mask_q <= '0;
        end else if (wr_inject) begin
            mask_q <= pwdata[CODE_W-1:0];
        end
    end

    // Commands fire in the access cycle so the encoder loads at that same edge
    always_comb begin
        cmd.encode_en   = wr_data;
        cmd.code_clear  = wr_ctrl && pwdata[0];
        cmd.count_clear = wr_ctrl && pwdata[1];
        cmd.inject_mask = mask_q;
        if (wr_data) begin
            cmd.data = pwdata[DATA_W-1:0];
        end else begin
            cmd.data = data_q;
        end
    end

    // Read multiplexer, write-only and unmapped offsets return zero
    always_comb begin
        case (paddr)
            REG_INJECT: begin
                rd_mux = {{(APB_DATA_W - CODE_W){1'b0}}, mask_q};
            end
            REG_CODE: begin
                rd_mux = {{(APB_DATA_W - CODE_W){1'b0}}, code};
            end
            REG_RESULT: begin
                rd_mux = {result.valid,
                          5'b0,
                          result.double_err,
                          result.single_err,
                          3'b0,
                          result.syndrome,
                          result.data};
            end
            REG_COUNT: begin
                rd_mux = {result.uncorrectable_count, result.corrected_count};
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    always_comb begin
        if (rd_en) begin
            prdata = rd_mux;
        end else begin
            prdata = '0;
        end
    end

endmodule

// File: ecc_pkg.sv
// Shared widths, APB register map and datapath structs for the SEC-DED block
// Imported by every module of the design and by the testbench
package ecc_pkg;

    localparam int DATA_W     = 16;
    localparam int HAM_W      = 21;
    localparam int CODE_W     = 22;
    localparam int SYN_W      = 5;
    localparam int CNT_W      = 16;
    localparam int ADDR_W     = 8;
    localparam int APB_DATA_W = 32;

    typedef logic [DATA_W-1:0] data_word_t;
    typedef logic [CODE_W-1:0] code_word_t;
    typedef logic [SYN_W-1:0]  syndrome_t;
    typedef logic [CNT_W-1:0]  err_count_t;
    typedef logic [ADDR_W-1:0] apb_addr_t;

    // Register map
    localparam apb_addr_t REG_DATA   = 8'h00;
    localparam apb_addr_t REG_INJECT = 8'h04;
    localparam apb_addr_t REG_CTRL   = 8'h08;
    localparam apb_addr_t REG_CODE   = 8'h0C;
    localparam apb_addr_t REG_RESULT = 8'h10;
    localparam apb_addr_t REG_COUNT  = 8'h14;

    typedef struct packed {
        logic       encode_en;
        logic       code_clear;
        logic       count_clear;
        data_word_t data;
        code_word_t inject_mask;
    } ecc_cmd_t;

    typedef struct packed {
        logic       valid;
        data_word_t data;
        syndrome_t  syndrome;
        logic       single_err;
        logic       double_err;
        err_count_t corrected_count;
        err_count_t uncorrectable_count;
    } ecc_result_t;

    // Data bits go to the non power of two positions, parity slots left at zero
    function automatic code_word_t place_data(input data_word_t d);
        code_word_t c;
        c        = '0;
        c[2]     = d[0];
        c[6:4]   = d[3:1];
        c[14:8]  = d[10:4];
        c[20:16] = d[15:11];
        return c;
    endfunction

    function automatic data_word_t extract_data(input code_word_t c);
        return {c[20:16], c[14:8], c[6:4], c[2]};
    endfunction

    // Bit k is the XOR of every position whose number has bit k set
    function automatic syndrome_t calc_syndrome(input code_word_t c);
        syndrome_t s;
        s = '0;
        for (int i = 0; i < HAM_W; i++) begin
            for (int k = 0; k < SYN_W; k++) begin
                if (((i + 1) & (1 << k)) != 0) begin
                    s[k] = s[k] ^ c[i];
                end
            end
        end
        return s;
    endfunction

endpackage

// File: ecc_top.sv
// Top level of the APB controlled SEC-DED block
// Register block feeds the encoder, the decoder reports back through it
`timescale 1ns/1ps

module ecc_top (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  ecc_pkg::apb_addr_t             paddr,
    input  logic [ecc_pkg::APB_DATA_W-1:0] pwdata,
    output logic [ecc_pkg::APB_DATA_W-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr
);
    import ecc_pkg::*;

    ecc_cmd_t    cmd;
    code_word_t  code;
    logic        encoded;
    ecc_result_t result;

    ecc_apb_regs u_regs (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd),
        .code    (code),
        .result  (result)
    );

    hamming_enc u_enc (
        .clock   (clock),
        .reset   (reset),
        .enable  (cmd.encode_en),
        .clear   (cmd.code_clear),
        .data    (cmd.data),
        .code    (code),
        .encoded (encoded)
    );

    hamming_dec u_dec (
        .clock       (clock),
        .reset       (reset),
        .code        (code),
        .inject_mask (cmd.inject_mask),
        .encoded     (encoded),
        .code_clear  (cmd.code_clear),
        .count_clear (cmd.count_clear),
        .result      (result)
    );

endmodule

// File: hamming_dec.sv
// SEC-DED decoder with error injection, single-bit correction and error counters
// Evaluates the injected codeword every cycle and registers the result
`timescale 1ns/1ps

module hamming_dec (
    input  logic                 clock,
    input  logic                 reset,
    input  ecc_pkg::code_word_t  code,
    input  ecc_pkg::code_word_t  inject_mask,
    input  logic                 encoded,
    input  logic                 code_clear,
    input  logic                 count_clear,
    output ecc_pkg::ecc_result_t result
);
    import ecc_pkg::*;

    code_word_t rx_code;
    code_word_t fixed_code;
    syndrome_t  syn;
    logic       overall_bad;
    logic       single_det;
    logic       double_det;

    logic       valid_q;
    data_word_t data_q;
    syndrome_t  syn_q;
    logic       single_q;
    logic       double_q;
    err_count_t corr_cnt;
    err_count_t uncorr_cnt;

    always_comb begin
        rx_code     = code ^ inject_mask;
        syn         = calc_syndrome(rx_code);
        overall_bad = ^rx_code;

        // Odd overall parity means one flipped bit, possibly bit 21 itself
        single_det = overall_bad;
        double_det = !overall_bad && (syn != '0);

        fixed_code = rx_code;
        if (overall_bad) begin
            for (int i = 0; i < HAM_W; i++) begin
                if (syn == syndrome_t'(i + 1)) begin
                    fixed_code[i] = ~rx_code[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            data_q   <= '0;
            syn_q    <= '0;
            single_q <= 1'b0;
            double_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            data_q   <= extract_data(fixed_code);
            syn_q    <= syn;
            single_q <= single_det;
            double_q <= double_det;
            if (code_clear) begin
                valid_q <= 1'b0;
            end else if (encoded) begin
                valid_q <= 1'b1;
            end
        end
    end

    // Counters only step on the encode strobe and saturate at all ones
    always_ff @(posedge clock) begin
        if (reset) begin
            corr_cnt   <= '0;
            uncorr_cnt <= '0;
        end else if (count_clear) begin
            corr_cnt   <= '0;
            uncorr_cnt <= '0;
        end else if (encoded) begin
            if (single_det && (corr_cnt != '1)) begin
                corr_cnt <= corr_cnt + 1'b1;
            end
            if (double_det && (uncorr_cnt != '1)) begin
                uncorr_cnt <= uncorr_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        result.valid               = valid_q;
        result.data                = data_q;
        result.syndrome            = syn_q;
        result.single_err          = single_q;
        result.double_err          = double_q;
        result.corrected_count     = corr_cnt;
        result.uncorrectable_count = uncorr_cnt;
    end

endmodule

// File: hamming_enc.sv
// Registered SEC-DED encoder, 16 data bits into an extended 22-bit Hamming codeword
// Loads on enable, synchronous clear wins over enable
`timescale 1ns/1ps

module hamming_enc (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable,
    input  logic                clear,
    input  ecc_pkg::data_word_t data,
    output ecc_pkg::code_word_t code,
    output logic                encoded
);
    import ecc_pkg::*;

    code_word_t next_code;
    syndrome_t  par;

    always_comb begin
        next_code = place_data(data);
        // Parity slots are still zero, so the syndrome is the parity to store
        par = calc_syndrome(next_code);
        next_code[0]  = par[0];
        next_code[1]  = par[1];
        next_code[3]  = par[2];
        next_code[7]  = par[3];
        next_code[15] = par[4];
        // Overall parity over the full Hamming word
        next_code[CODE_W-1] = ^next_code[HAM_W-1:0];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            code <= '0;
        end else if (clear) begin
            code <= '0;
        end else if (enable) begin
            code <= next_code;
        end
    end

    // One cycle strobe alongside the freshly loaded codeword
    always_ff @(posedge clock) begin
        if (reset) begin
            encoded <= 1'b0;
        end else begin
            encoded <= enable;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the ECC testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_ecc
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_ecc \
    -f ecc.f \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG_FILE"; then
    echo "Simulation reported failures"
    exit 1
fi

if ! grep -q "NO ERRORS" "$LOG_FILE"; then
    echo "Simulation ended without a pass report"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: tb_ecc_tasks.svh
// APB bus tasks, LFSR random source and reference SEC-DED model for the ECC testbench
// Included inside the testbench module body
`ifndef TB_ECC_TASKS_SVH
`define TB_ECC_TASKS_SVH

task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
    @(negedge clock);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    penable = 1'b0;
    @(negedge clock);
    penable = 1'b1;
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

// Sampled before the access edge, then queued for the compare process
task automatic read_check(input apb_addr_t addr, input logic [31:0] expected,
                          input string name);
    @(negedge clock);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    penable = 1'b0;
    @(negedge clock);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    exp_q.push_back(expected);
    obs_q.push_back(prdata);
    name_q.push_back(name);
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
endtask

// Taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic draw_bits(input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
endtask

function automatic logic [4:0] syndrome_of(input logic [21:0] c);
    logic [4:0] s;
    int p;
    int k;
    s = '0;
    for (p = 1; p <= 21; p++) begin
        for (k = 0; k < 5; k++) begin
            if ((p & (1 << k)) != 0) begin
                s[k] = s[k] ^ c[p-1];
            end
        end
    end
    return s;
endfunction

// Data bits fill the positions that are not powers of two, lowest first
function automatic logic [21:0] codeword_of(input logic [15:0] d);
    logic [21:0] c;
    logic [4:0]  par;
    int p;
    int di;
    c  = '0;
    di = 0;
    for (p = 1; p <= 21; p++) begin
        if ((p & (p - 1)) != 0) begin
            c[p-1] = d[di];
            di++;
        end
    end
    // With the parity slots still zero the syndrome is the parity itself
    par   = syndrome_of(c);
    c[0]  = par[0];
    c[1]  = par[1];
    c[3]  = par[2];
    c[7]  = par[3];
    c[15] = par[4];
    c[21] = ^c[20:0];
    return c;
endfunction

function automatic logic [15:0] data_of(input logic [21:0] c);
    logic [15:0] d;
    int p;
    int di;
    d  = '0;
    di = 0;
    for (p = 1; p <= 21; p++) begin
        if ((p & (p - 1)) != 0) begin
            d[di] = c[p-1];
            di++;
        end
    end
    return d;
endfunction

// Expected REG_RESULT image for a received codeword
function automatic logic [31:0] expected_result(input logic [21:0] c, input logic valid);
    logic [4:0]  s;
    logic [21:0] fixed;
    logic        odd;
    logic        sgl;
    logic        dbl;
    int          sp;
    s     = syndrome_of(c);
    odd   = ^c;
    fixed = c;
    sp    = int'(s);
    if (odd && (sp >= 1) && (sp <= 21)) begin
        fixed[sp-1] = ~fixed[sp-1];
    end
    sgl = odd;
    dbl = !odd && (s != '0);
    return {valid, 5'b0, dbl, sgl, 3'b0, s, data_of(fixed)};
endfunction

`endif

// File: tb_ecc.sv
// Testbench for the APB controlled SEC-DED block
// Runs clean, single error, double error and clear sequences against a reference model
`timescale 1ns/1ps

module tb_ecc;
    import ecc_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int N_CLEAN         = 20;
    localparam int N_SINGLE        = 24;
    localparam int N_DOUBLE        = 20;
    localparam int NUM_TRANS       = 3 + 6 * (N_CLEAN + N_SINGLE + N_DOUBLE) + 9;
    localparam int WATCHDOG_CYCLES = NUM_TRANS * 4 + 100;

    logic        clock = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [15:0] lfsr_state;
    err_count_t  exp_corrected;
    err_count_t  exp_uncorrectable;
    int          num_checks;
    int          num_mismatches;
    int          num_other;

    logic [31:0] exp_q[$];
    logic [31:0] obs_q[$];
    string       name_q[$];

    `include "tb_ecc_tasks.svh"

    always #(CLK_PERIOD / 2) clock = ~clock;

    ecc_top i_dut (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // Compare process for queued readbacks
    always @(negedge clock) begin
        logic [31:0] got;
        logic [31:0] want;
        string       sig;
        while (obs_q.size() > 0) begin
            got  = obs_q.pop_front();
            want = exp_q.pop_front();
            sig  = name_q.pop_front();
            num_checks++;
            if (got !== want) begin
                num_mismatches++;
                $display("MISMATCH %s: got 0x%08h expected 0x%08h at %0t", sig, got, want, $time);
            end
        end
    end

    always @(negedge clock) begin
        if (!reset && ((pslverr !== 1'b0) || (pready !== 1'b1))) begin
            num_other++;
            $display("APB response is not ready without error at %0t", $time);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic encode_and_check(input data_word_t data, input code_word_t mask);
        code_word_t  code;
        logic [31:0] res;
        code = codeword_of(data);
        res  = expected_result(code ^ mask, 1'b1);
        apb_write(REG_INJECT, {10'b0, mask});
        read_check(REG_INJECT, {10'b0, mask}, "inject");
        apb_write(REG_DATA, {16'b0, data});
        if (res[24]) begin
            exp_corrected++;
        end
        if (res[25]) begin
            exp_uncorrectable++;
        end
        read_check(REG_CODE, {10'b0, code}, "code");
        read_check(REG_RESULT, res, "result");
        read_check(REG_COUNT, {exp_uncorrectable, exp_corrected}, "count");
    endtask

    initial begin
        logic [31:0] rnd;
        data_word_t  data;
        code_word_t  mask;
        int          pos_a;
        int          pos_b;
        reset             = 1'b1;
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        paddr             = '0;
        pwdata            = '0;
        lfsr_state        = 16'd5;
        exp_corrected     = '0;
        exp_uncorrectable = '0;
        num_checks        = 0;
        num_mismatches    = 0;
        num_other         = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        read_check(REG_CODE, 32'h0, "code after reset");
        read_check(REG_RESULT, 32'h0, "result after reset");
        read_check(REG_COUNT, 32'h0, "count after reset");

        for (int i = 0; i < N_CLEAN; i++) begin
            draw_bits(16, rnd);
            data = rnd[15:0];
            encode_and_check(data, '0);
        end

        // First single error hits the overall parity bit
        for (int i = 0; i < N_SINGLE; i++) begin
            draw_bits(16, rnd);
            data = rnd[15:0];
            draw_bits(5, rnd);
            pos_a = (i == 0) ? 21 : int'(rnd % 22);
            mask = code_word_t'(1) << pos_a;
            encode_and_check(data, mask);
        end

        for (int i = 0; i < N_DOUBLE; i++) begin
            draw_bits(16, rnd);
            data = rnd[15:0];
            draw_bits(5, rnd);
            pos_a = int'(rnd % 22);
            draw_bits(5, rnd);
            pos_b = (pos_a + 1 + int'(rnd % 21)) % 22;
            mask = (code_word_t'(1) << pos_a) | (code_word_t'(1) << pos_b);
            encode_and_check(data, mask);
        end

        apb_write(REG_INJECT, 32'h0);
        apb_write(REG_CTRL, 32'h1);
        read_check(REG_CODE, 32'h0, "code after clear");
        read_check(REG_RESULT, 32'h0, "result after clear");
        read_check(REG_COUNT, {exp_uncorrectable, exp_corrected}, "count kept");
        apb_write(REG_CTRL, 32'h2);
        exp_corrected     = '0;
        exp_uncorrectable = '0;
        read_check(REG_COUNT, 32'h0, "count after clear");
        read_check(8'h20, 32'h0, "unmapped 0x20");
        read_check(8'hFC, 32'h0, "unmapped 0xFC");

        repeat (2) @(negedge clock);
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 num_checks, num_mismatches, num_other);
        if ((num_mismatches == 0) && (num_other == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
